// ==== Bender.yml ====
package:
  name: ahb_lite_matrix

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ahb_lite_pkg.sv
      - rtl/ahb_lite_decoder.sv
      - rtl/ahb_ram_slave.sv
      - rtl/ahb_busy_ram_slave.sv
      - rtl/ahb_gpio_slave.sv
      - rtl/ahb_default_slave.sv
      - rtl/ahb_lite_response_mux.sv
      - rtl/ahb_lite_matrix.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/ahb_lite_matrix_asserts.sv
      - tests/ahb_lite_matrix_tb.sv

// ==== rtl/ahb_busy_ram_slave.sv ====
`timescale 1ns/1ps
`include "ahb_lite_defs.svh"

module ahb_busy_ram_slave
    import ahb_lite_pkg::*;
#(
    parameter int ADDR_WIDTH = `AHB_RAM_ADDR_WIDTH
)
(
    input  logic        HCLK,
    input  logic        reset,
    input  logic        sel,
    input  ahb_req_t    req,
    input  logic        hready,
    input  logic [31:0] hwdata,
    output ahb_rsp_t    rsp
);

    localparam int CNT_W = $clog2(`AHB_RAM_WAIT_STATES + 1);

    logic [31:0]           mem [2**ADDR_WIDTH];

    logic                  accept;
    logic                  pending;        // In a data phase
    logic [CNT_W-1:0]      wait_cnt;       // Wait cycles still to go
    logic                  dp_write;
    logic [ADDR_WIDTH-1:0] dp_addr;
    logic [3:0]            dp_lanes;
    logic [31:0]           rdata_q;

    assign accept = sel && hready && is_active(req.trans);

    always_ff @(posedge HCLK) begin
        if (reset) begin
            pending  <= 1'b0;
            wait_cnt <= '0;
        end else begin
            if (hready) begin
                pending <= accept;
            end
            if (accept) begin
                wait_cnt <= CNT_W'(`AHB_RAM_WAIT_STATES);
            end else if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (accept) begin
            dp_write <= req.write;
            dp_addr  <= req.addr[ADDR_WIDTH+1:2];
            dp_lanes <= byte_lanes(req.size, req.addr[1:0]);
        end
        // Read on the edge into the final data-phase cycle
        if (pending && !dp_write && (wait_cnt == CNT_W'(1))) begin
            rdata_q <= mem[dp_addr];
        end
        if (pending && dp_write && hready) begin
            for (int i = 0; i < 4; i++) begin
                if (dp_lanes[i]) begin
                    mem[dp_addr][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    assign rsp = '{rdata: rdata_q, ready: (wait_cnt == '0), resp: 1'b0};

endmodule

// ==== rtl/ahb_default_slave.sv ====
`timescale 1ns/1ps

module ahb_default_slave
    import ahb_lite_pkg::*;
(
    input  logic     HCLK,
    input  logic     reset,
    input  logic     sel,
    input  ahb_req_t req,
    input  logic     hready,
    output ahb_rsp_t rsp
);

    dflt_state_t state;
    logic        err_tail;     // Second cycle of the ERROR response
    logic        accept;

    assign accept = sel && hready && is_active(req.trans);

    always_ff @(posedge HCLK) begin
        if (reset) begin
            state    <= DFLT_OK;
            err_tail <= 1'b0;
        end else begin
            err_tail <= (state == DFLT_ERR);
            case (state)
                DFLT_OK: begin
                    if (accept) begin
                        state <= DFLT_ERR;
                    end
                end
                DFLT_ERR: state <= DFLT_OK;     // HREADY is low, nothing new arrives
                default:  state <= DFLT_OK;
            endcase
        end
    end

    assign rsp = '{rdata: 32'h0,
                   ready: (state != DFLT_ERR),
                   resp:  (state == DFLT_ERR) || err_tail};

endmodule

// ==== rtl/ahb_gpio_slave.sv ====
`timescale 1ns/1ps
`include "ahb_lite_defs.svh"

module ahb_gpio_slave
    import ahb_lite_pkg::*;
(
    input  logic                         HCLK,
    input  logic                         reset,
    input  logic                         sel,
    input  ahb_req_t                     req,
    input  logic                         hready,
    input  logic [31:0]                  hwdata,
    input  logic [`AHB_N_SWITCHES-1:0]   switches,
    input  logic [`AHB_N_BUTTONS-1:0]    buttons,
    output ahb_rsp_t                     rsp,
    output logic [`AHB_N_RED_LEDS-1:0]   red_leds,
    output logic [`AHB_N_GREEN_LEDS-1:0] green_leds,
    output logic [`AHB_HEX_WIDTH-1:0]    hex
);

    logic                       accept;
    logic                       wr_pending;    // Word write in its data phase
    logic [2:0]                 dp_reg;        // Register offset of the data phase
    logic [`AHB_N_SWITCHES-1:0] switches_q;
    logic [`AHB_N_BUTTONS-1:0]  buttons_q;
    logic [31:0]                rdata;

    assign accept = sel && hready && is_active(req.trans);

    always_ff @(posedge HCLK) begin
        if (reset) begin
            wr_pending <= 1'b0;
            red_leds   <= '0;
            green_leds <= '0;
            hex        <= '0;
        end else begin
            if (hready) begin
                wr_pending <= accept && req.write && (req.size == WORD);
            end
            if (wr_pending && hready) begin
                case (dp_reg)
                    `AHB_GPIO_RED:   red_leds   <= hwdata[`AHB_N_RED_LEDS-1:0];
                    `AHB_GPIO_GREEN: green_leds <= hwdata[`AHB_N_GREEN_LEDS-1:0];
                    `AHB_GPIO_HEX:   hex        <= hwdata[`AHB_HEX_WIDTH-1:0];
                    default: ;                      // Inputs and unused offsets
                endcase
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            dp_reg <= req.addr[4:2];
        end
        switches_q <= switches;
        buttons_q  <= buttons;
    end

    // Read mux, zero-extended
    always_comb begin
        case (dp_reg)
            `AHB_GPIO_RED:      rdata = 32'(red_leds);
            `AHB_GPIO_GREEN:    rdata = 32'(green_leds);
            `AHB_GPIO_HEX:      rdata = 32'(hex);
            `AHB_GPIO_SWITCHES: rdata = 32'(switches_q);
            `AHB_GPIO_BUTTONS:  rdata = 32'(buttons_q);
            default:            rdata = 32'h0;
        endcase
    end

    assign rsp = '{rdata: rdata, ready: 1'b1, resp: 1'b0};

endmodule

// ==== rtl/ahb_lite_decoder.sv ====
`timescale 1ns/1ps
`include "ahb_lite_defs.svh"

module ahb_lite_decoder
    import ahb_lite_pkg::*;
(
    input  ahb_req_t req,
    output hsel_t    hsel
);

    // Regions are disjoint since both upper matches have bit 28 set
    always_comb begin
        hsel.reset_ram = (req.addr[28:22] == `AHB_RESET_RAM_MATCH);
        hsel.gpio      = (req.addr[28:22] == `AHB_GPIO_MATCH);
        hsel.ram       = (req.addr[28] == `AHB_RAM_MATCH);      // Lower 256 MB
        hsel.none      = !(hsel.reset_ram || hsel.gpio || hsel.ram);
    end

endmodule

// ==== rtl/ahb_lite_defs.svh ====
`ifndef AHB_LITE_DEFS_SVH
`define AHB_LITE_DEFS_SVH

// Region matches on physical address bits 28:22
`define AHB_RESET_RAM_MATCH       7'h7f   // 0x1fc00000
`define AHB_GPIO_MATCH            7'h7e   // 0x1f800000
`define AHB_RAM_MATCH             1'b0    // Bit 28 only, 0x00000000

// Word-address widths of the two RAMs
`define AHB_RESET_RAM_ADDR_WIDTH  10
`define AHB_RAM_ADDR_WIDTH        12

`define AHB_RAM_WAIT_STATES       2       // Low-HREADY cycles per busy RAM access

// GPIO pin counts
`define AHB_N_SWITCHES            18
`define AHB_N_BUTTONS             5
`define AHB_N_RED_LEDS            18
`define AHB_N_GREEN_LEDS          8
`define AHB_HEX_WIDTH             32

// GPIO registers, selected by byte address bits 4:2
`define AHB_GPIO_RED              3'd0
`define AHB_GPIO_GREEN            3'd1
`define AHB_GPIO_HEX              3'd2
`define AHB_GPIO_SWITCHES         3'd3
`define AHB_GPIO_BUTTONS          3'd4

`endif

// ==== rtl/ahb_lite_matrix.sv ====
`timescale 1ns/1ps
`include "ahb_lite_defs.svh"

module ahb_lite_matrix
    import ahb_lite_pkg::*;
(
    input  logic                         HCLK,
    input  logic                         reset,
    input  logic [31:0]                  HADDR,
    input  logic [1:0]                   HTRANS,
    input  logic [2:0]                   HSIZE,
    input  logic                         HWRITE,
    input  logic [31:0]                  HWDATA,
    output logic [31:0]                  HRDATA,
    output logic                         HREADY,
    output logic                         HRESP,
    input  logic [`AHB_N_SWITCHES-1:0]   IO_Switches,
    input  logic [`AHB_N_BUTTONS-1:0]    IO_Buttons,
    output logic [`AHB_N_RED_LEDS-1:0]   IO_RedLEDs,
    output logic [`AHB_N_GREEN_LEDS-1:0] IO_GreenLEDs,
    output logic [`AHB_HEX_WIDTH-1:0]    IO_7_SegmentHEX
);

    ahb_req_t req;
    hsel_t    hsel;
    ahb_rsp_t rsp_reset_ram;
    ahb_rsp_t rsp_ram;
    ahb_rsp_t rsp_gpio;
    ahb_rsp_t rsp_none;

    assign req = '{addr:  HADDR,
                   trans: htrans_t'(HTRANS),
                   size:  hsize_t'(HSIZE),
                   write: HWRITE};

    // Idle slaves report ready, so only the data-phase owner can stall
    assign HREADY = rsp_reset_ram.ready & rsp_ram.ready & rsp_gpio.ready & rsp_none.ready;

    // ------------------------------------------------------------------------
    ahb_lite_decoder decoder (
        .req  (req),
        .hsel (hsel)
    );

    ahb_ram_slave #(
        .ADDR_WIDTH (`AHB_RESET_RAM_ADDR_WIDTH)
    ) reset_ram (
        .HCLK   (HCLK),
        .reset  (reset),
        .sel    (hsel.reset_ram),
        .req    (req),
        .hready (HREADY),
        .hwdata (HWDATA),
        .rsp    (rsp_reset_ram)
    );

    ahb_busy_ram_slave #(
        .ADDR_WIDTH (`AHB_RAM_ADDR_WIDTH)
    ) ram (
        .HCLK   (HCLK),
        .reset  (reset),
        .sel    (hsel.ram),
        .req    (req),
        .hready (HREADY),
        .hwdata (HWDATA),
        .rsp    (rsp_ram)
    );

    ahb_gpio_slave gpio (
        .HCLK       (HCLK),
        .reset      (reset),
        .sel        (hsel.gpio),
        .req        (req),
        .hready     (HREADY),
        .hwdata     (HWDATA),
        .switches   (IO_Switches),
        .buttons    (IO_Buttons),
        .rsp        (rsp_gpio),
        .red_leds   (IO_RedLEDs),
        .green_leds (IO_GreenLEDs),
        .hex        (IO_7_SegmentHEX)
    );

    ahb_default_slave default_slave (
        .HCLK   (HCLK),
        .reset  (reset),
        .sel    (hsel.none),
        .req    (req),
        .hready (HREADY),
        .rsp    (rsp_none)
    );

    // ------------------------------------------------------------------------
    ahb_lite_response_mux response_mux (
        .HCLK          (HCLK),
        .reset         (reset),
        .hready        (HREADY),
        .hsel          (hsel),
        .rsp_reset_ram (rsp_reset_ram),
        .rsp_ram       (rsp_ram),
        .rsp_gpio      (rsp_gpio),
        .rsp_none      (rsp_none),
        .rdata         (HRDATA),
        .resp          (HRESP)
    );

endmodule

// ==== rtl/ahb_lite_pkg.sv ====
package ahb_lite_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // Address-phase signals
    typedef struct packed {
        logic [31:0] addr;
        htrans_t     trans;
        hsize_t      size;
        logic        write;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
        logic        resp;   // 1 is ERROR
    } ahb_rsp_t;

    typedef struct packed {
        logic reset_ram;
        logic ram;
        logic gpio;
        logic none;          // Unmapped address
    } hsel_t;

    typedef enum logic {
        DFLT_OK,
        DFLT_ERR
    } dflt_state_t;

    // ------------------------------------------------------------------------
    function automatic logic is_active(htrans_t trans);
        return (trans == NONSEQ) || (trans == SEQ);
    endfunction

    // Little-endian byte strobes of one transfer
    function automatic logic [3:0] byte_lanes(hsize_t size, logic [1:0] offset);
        logic [3:0] lanes;
        case (size)
            BYTE:    lanes = 4'b0001 << offset;
            HALF:    lanes = 4'b0011 << {offset[1], 1'b0};
            default: lanes = 4'b1111;
        endcase
        return lanes;
    endfunction

endpackage

// ==== rtl/ahb_lite_response_mux.sv ====
`timescale 1ns/1ps

module ahb_lite_response_mux
    import ahb_lite_pkg::*;
(
    input  logic        HCLK,
    input  logic        reset,
    input  logic        hready,
    input  hsel_t       hsel,
    input  ahb_rsp_t    rsp_reset_ram,
    input  ahb_rsp_t    rsp_ram,
    input  ahb_rsp_t    rsp_gpio,
    input  ahb_rsp_t    rsp_none,
    output logic [31:0] rdata,
    output logic        resp
);

    hsel_t hsel_q;             // Owner of the current data phase

    always_ff @(posedge HCLK) begin
        if (reset) begin
            hsel_q <= '0;
        end else if (hready) begin
            hsel_q <= hsel;
        end
    end

    always_comb begin
        rdata = 32'h0;
        resp  = 1'b0;
        if (hsel_q.reset_ram) begin
            rdata = rsp_reset_ram.rdata;
            resp  = rsp_reset_ram.resp;
        end else if (hsel_q.ram) begin
            rdata = rsp_ram.rdata;
            resp  = rsp_ram.resp;
        end else if (hsel_q.gpio) begin
            rdata = rsp_gpio.rdata;
            resp  = rsp_gpio.resp;
        end else if (hsel_q.none) begin
            rdata = rsp_none.rdata;
            resp  = rsp_none.resp;
        end
    end

endmodule

// ==== rtl/ahb_ram_slave.sv ====
`timescale 1ns/1ps
`include "ahb_lite_defs.svh"

module ahb_ram_slave
    import ahb_lite_pkg::*;
#(
    parameter int ADDR_WIDTH = `AHB_RESET_RAM_ADDR_WIDTH
)
(
    input  logic        HCLK,
    input  logic        reset,
    input  logic        sel,
    input  ahb_req_t    req,
    input  logic        hready,
    input  logic [31:0] hwdata,
    output ahb_rsp_t    rsp
);

    logic [31:0]           mem [2**ADDR_WIDTH];

    logic                  accept;
    logic [ADDR_WIDTH-1:0] raddr;          // Word of the current address phase
    logic                  wr_pending;     // Write data phase in progress
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [1:0]            wr_offset;
    hsize_t                wr_size;
    logic [3:0]            wr_lanes;
    logic [31:0]           rd_word;
    logic [31:0]           rdata_q;

    assign accept   = sel && hready && is_active(req.trans);
    assign raddr    = req.addr[ADDR_WIDTH+1:2];
    assign wr_lanes = byte_lanes(wr_size, wr_offset);

    // A read overlapping a write to the same word sees the new bytes
    always_comb begin
        rd_word = mem[raddr];
        if (wr_pending && (wr_addr == raddr)) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_lanes[i]) begin
                    rd_word[8*i +: 8] = hwdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (reset) begin
            wr_pending <= 1'b0;
        end else if (hready) begin
            wr_pending <= accept && req.write;
        end
    end

    // ------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (accept && req.write) begin
            wr_addr   <= raddr;
            wr_offset <= req.addr[1:0];
            wr_size   <= req.size;
        end
        if (accept && !req.write) begin
            rdata_q <= rd_word;                     // Ready in the next cycle
        end
        if (wr_pending && hready) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_lanes[i]) begin
                    mem[wr_addr][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    assign rsp = '{rdata: rdata_q, ready: 1'b1, resp: 1'b0};

endmodule

// ==== tests/ahb_lite_matrix_asserts.sv ====
`timescale 1ns/1ps

module ahb_lite_matrix_asserts
    import ahb_lite_pkg::*;
(
    input logic     HCLK,
    input logic     reset,
    input hsel_t    hsel,
    input ahb_req_t req,
    input logic     HREADY,
    input logic     HRESP
);

    logic        dp_err;            // Data phase belongs to an active unmapped transfer
    int unsigned fail_count = 0;

    always_ff @(posedge HCLK) begin
        if (reset) begin
            dp_err <= 1'b0;
        end else if (HREADY) begin
            dp_err <= hsel.none && ((req.trans == NONSEQ) || (req.trans == SEQ));
        end
    end

    // ------------------------------------------------------------------------
    err_second_cycle: assert property (@(posedge HCLK) disable iff (reset)
        (HRESP && !HREADY) |=> (HRESP && HREADY))
        else begin
            $error("ERROR response without its second cycle");
            fail_count++;
        end

    okay_outside_err: assert property (@(posedge HCLK) disable iff (reset)
        !dp_err |-> !HRESP)
        else begin
            $error("HRESP high outside an error data phase");
            fail_count++;
        end

    ready_after_reset: assert property (@(posedge HCLK) $fell(reset) |-> HREADY)
        else begin
            $error("HREADY low in the first cycle after reset");
            fail_count++;
        end

endmodule

bind ahb_lite_matrix ahb_lite_matrix_asserts asserts (
    .HCLK   (HCLK),
    .reset  (reset),
    .hsel   (hsel),
    .req    (req),
    .HREADY (HREADY),
    .HRESP  (HRESP)
);

// ==== tests/ahb_lite_matrix_tb.sv ====
`timescale 1ns/1ps
`include "ahb_lite_defs.svh"

module ahb_lite_matrix_tb
    import ahb_lite_pkg::*;
();

    localparam logic [31:0] RESET_RAM_BASE = 32'h1fc0_0000;
    localparam logic [31:0] RAM_BASE       = 32'h0000_0000;
    localparam logic [31:0] GPIO_BASE      = 32'h1f80_0000;
    localparam logic [31:0] UNMAPPED       = 32'h1000_0000;
    localparam int          MODEL_WORDS    = 64;
    localparam int          MAX_WAITS      = 20;

    logic                         HCLK;
    logic                         reset;
    logic [31:0]                  HADDR;
    logic [1:0]                   HTRANS;
    logic [2:0]                   HSIZE;
    logic                         HWRITE;
    logic [31:0]                  HWDATA;
    logic [31:0]                  HRDATA;
    logic                         HREADY;
    logic                         HRESP;
    logic [`AHB_N_SWITCHES-1:0]   switches;
    logic [`AHB_N_BUTTONS-1:0]    buttons;
    logic [`AHB_N_RED_LEDS-1:0]   red_leds;
    logic [`AHB_N_GREEN_LEDS-1:0] green_leds;
    logic [`AHB_HEX_WIDTH-1:0]    hex;

    // Reference model
    logic [31:0]                  reset_ram_model [MODEL_WORDS];
    logic [31:0]                  ram_model [MODEL_WORDS];
    logic [`AHB_N_RED_LEDS-1:0]   red_model;
    logic [`AHB_N_GREEN_LEDS-1:0] green_model;
    logic [`AHB_HEX_WIDTH-1:0]    hex_model;
    logic [31:0]                  lcg_state = 32'h238f_e774;

    // Transfer currently in its data phase
    logic                         dp_active;
    logic [31:0]                  dp_addr;
    hsize_t                       dp_size;
    logic                         dp_write;
    logic [31:0]                  dp_wdata;

    ahb_lite_matrix DUT (
        .HCLK            (HCLK),
        .reset           (reset),
        .HADDR           (HADDR),
        .HTRANS          (HTRANS),
        .HSIZE           (HSIZE),
        .HWRITE          (HWRITE),
        .HWDATA          (HWDATA),
        .HRDATA          (HRDATA),
        .HREADY          (HREADY),
        .HRESP           (HRESP),
        .IO_Switches     (switches),
        .IO_Buttons      (buttons),
        .IO_RedLEDs      (red_leds),
        .IO_GreenLEDs    (green_leds),
        .IO_7_SegmentHEX (hex)
    );

    initial HCLK = 1'b0;
    always #4 HCLK = ~HCLK;

    // ------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // 0 reset RAM, 1 busy RAM, 2 GPIO, 3 unmapped
    function automatic int region_of(logic [31:0] addr);
        if (addr[28:22] == `AHB_RESET_RAM_MATCH) return 0;
        if (addr[28:22] == `AHB_GPIO_MATCH) return 2;
        if (addr[28] == `AHB_RAM_MATCH) return 1;
        return 3;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wdata,
                                                hsize_t size, logic [1:0] offs);
        logic [31:0] word;
        word = old;
        case (size)
            BYTE:    word[8*offs +: 8] = wdata[8*offs +: 8];
            HALF:    word[16*offs[1] +: 16] = wdata[16*offs[1] +: 16];
            default: word = wdata;
        endcase
        return word;
    endfunction

    function automatic logic [31:0] gpio_read(logic [2:0] offs);
        case (offs)
            `AHB_GPIO_RED:      return 32'(red_model);
            `AHB_GPIO_GREEN:    return 32'(green_model);
            `AHB_GPIO_HEX:      return 32'(hex_model);
            `AHB_GPIO_SWITCHES: return 32'(switches);
            `AHB_GPIO_BUTTONS:  return 32'(buttons);
            default:            return 32'h0;
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        stop_with_failure();
    endtask

    task automatic check_pins();
        assert (red_leds == red_model)
            else report_mismatch("red LEDs", 32'(red_leds), 32'(red_model));
        assert (green_leds == green_model)
            else report_mismatch("green LEDs", 32'(green_leds), 32'(green_model));
        assert (hex == hex_model) else report_mismatch("hex", hex, hex_model);
    endtask

    // Ends the current data phase against the model
    // HRDATA and HRESP are sampled with HREADY high
    task automatic retire(input int waits);
        int          region;
        int          exp_waits;
        logic        exp_err;
        logic [31:0] exp_rdata;
        logic [5:0]  idx;
        region    = region_of(dp_addr);
        idx       = dp_addr[7:2];
        exp_err   = dp_active && (region == 3);
        exp_waits = !dp_active ? 0 : (region == 1) ? `AHB_RAM_WAIT_STATES : exp_err ? 1 : 0;
        exp_rdata = 32'h0;
        if (dp_active) begin
            case (region)
                0: if (dp_write) reset_ram_model[idx] =
                       merge_bytes(reset_ram_model[idx], dp_wdata, dp_size, dp_addr[1:0]);
                   else exp_rdata = reset_ram_model[idx];
                1: if (dp_write) ram_model[idx] =
                       merge_bytes(ram_model[idx], dp_wdata, dp_size, dp_addr[1:0]);
                   else exp_rdata = ram_model[idx];
                2: if (!dp_write) begin
                       exp_rdata = gpio_read(dp_addr[4:2]);
                   end else if (dp_size == WORD) begin   // Narrow writes are ignored
                       case (dp_addr[4:2])
                           `AHB_GPIO_RED:   red_model   = dp_wdata[`AHB_N_RED_LEDS-1:0];
                           `AHB_GPIO_GREEN: green_model = dp_wdata[`AHB_N_GREEN_LEDS-1:0];
                           `AHB_GPIO_HEX:   hex_model   = dp_wdata[`AHB_HEX_WIDTH-1:0];
                           default: ;
                       endcase
                   end
                default: ;
            endcase
        end
        assert (waits == exp_waits)
            else report_mismatch("wait cycles", 32'(waits), 32'(exp_waits));
        assert (HRESP == exp_err) else report_mismatch("HRESP", 32'(HRESP), 32'(exp_err));
        if (dp_active && !dp_write) begin
            assert (HRDATA == exp_rdata) else report_mismatch("HRDATA", HRDATA, exp_rdata);
        end
    endtask

    // Drives one address phase and waits out the stall of the previous data phase
    task automatic issue(input logic [31:0] addr, input htrans_t trans, input hsize_t size,
                         input logic write, input logic [31:0] wdata);
        int waits;
        HADDR  = addr;
        HTRANS = trans;
        HSIZE  = size;
        HWRITE = write;
        HWDATA = dp_wdata;
        waits  = 0;
        @(negedge HCLK);
        while (!HREADY) begin
            waits++;
            if (waits > MAX_WAITS) begin
                $display("HREADY stayed low for too long at %0t", $time);
                stop_with_failure();
            end
            @(negedge HCLK);
        end
        retire(waits);
        @(posedge HCLK);
        #1;
        dp_active = (trans == NONSEQ) || (trans == SEQ);
        dp_addr   = addr;
        dp_size   = size;
        dp_write  = write;
        dp_wdata  = wdata;
        check_pins();
    endtask

    // Concurrent assertion failures end the run at once
    always @(negedge HCLK) begin
        if (DUT.asserts.fail_count != 0) begin
            $display("A protocol assertion failed before %0t", $time);
            stop_with_failure();
        end
    end

    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [1:0]  off;
        hsize_t      sz;
        HADDR       = 32'h0;
        HTRANS      = IDLE;
        HSIZE       = WORD;
        HWRITE      = 1'b0;
        HWDATA      = 32'h0;
        switches    = 18'h2_a5c3;
        buttons     = 5'h15;
        reset       = 1'b1;
        dp_active   = 1'b0;
        dp_addr     = 32'h0;
        dp_size     = WORD;
        dp_write    = 1'b0;
        dp_wdata    = 32'h0;
        red_model   = '0;
        green_model = '0;
        hex_model   = '0;
        repeat (8) @(posedge HCLK);
        #1 reset = 1'b0;

        assert (HREADY === 1'b1 && HRESP === 1'b0)
            else report_mismatch("HREADY and HRESP after reset", {HREADY, HRESP}, 32'h2);
        check_pins();

        // Fill both RAM models with full words
        for (int i = 0; i < MODEL_WORDS; i++) begin
            issue(RESET_RAM_BASE + 32'(4 * i), NONSEQ, WORD, 1'b1, lcg_next());
            issue(RAM_BASE + 32'(4 * i), NONSEQ, WORD, 1'b1, lcg_next());
        end

        // Byte lanes in both RAMs, each read follows its writes back to back
        for (int k = 0; k < 2; k++) begin
            a = (k == 0) ? RESET_RAM_BASE : RAM_BASE;
            for (int b = 0; b < 4; b++) begin
                issue(a + 32'h20 + 32'(b), NONSEQ, BYTE, 1'b1, lcg_next());
            end
            issue(a + 32'h20, NONSEQ, WORD, 1'b0, 32'h0);
            issue(a + 32'h24, NONSEQ, HALF, 1'b1, lcg_next());
            issue(a + 32'h26, NONSEQ, BYTE, 1'b1, lcg_next());
            issue(a + 32'h24, NONSEQ, WORD, 1'b0, 32'h0);
            issue(a + 32'h2a, NONSEQ, HALF, 1'b1, lcg_next());
            issue(a + 32'h28, NONSEQ, WORD, 1'b0, 32'h0);
        end

        // GPIO registers, including an ignored write to the switches
        issue(GPIO_BASE + 32'h00, NONSEQ, WORD, 1'b1, 32'hffff_ffff);
        issue(GPIO_BASE + 32'h04, NONSEQ, WORD, 1'b1, 32'h1234_56a5);
        issue(GPIO_BASE + 32'h08, NONSEQ, WORD, 1'b1, 32'hdead_beef);
        issue(GPIO_BASE + 32'h0c, NONSEQ, WORD, 1'b1, 32'hffff_ffff);
        issue(GPIO_BASE + 32'h08, NONSEQ, BYTE, 1'b1, 32'h0000_0011);
        for (int g = 0; g < 8; g++) begin
            issue(GPIO_BASE + 32'(4 * g), NONSEQ, WORD, 1'b0, 32'h0);
        end

        // Unmapped access, IDLE to the same address, then a mapped read
        issue(UNMAPPED, NONSEQ, WORD, 1'b0, 32'h0);
        issue(UNMAPPED, IDLE, WORD, 1'b0, 32'h0);
        issue(RESET_RAM_BASE + 32'h20, NONSEQ, WORD, 1'b0, 32'h0);
        issue(UNMAPPED + 32'h40, NONSEQ, WORD, 1'b1, 32'h5555_aaaa);
        issue(RAM_BASE + 32'h24, NONSEQ, WORD, 1'b0, 32'h0);

        switches = 18'h1_0f0f;
        buttons  = 5'h0a;
        for (int n = 0; n < 400; n++) begin
            r = lcg_next();
            case (r[31:30])
                2'd0:    a = RESET_RAM_BASE;
                2'd1:    a = RAM_BASE;
                2'd2:    a = GPIO_BASE;
                default: a = r[29] ? UNMAPPED : RAM_BASE;
            endcase
            sz = (r[12:11] == 2'd3) ? WORD : hsize_t'({1'b0, r[12:11]});
            case (sz)
                BYTE:    off = r[1:0];
                HALF:    off = {r[1], 1'b0};
                default: off = 2'b00;
            endcase
            issue(a + {24'h0, r[9:4], off}, (r[15:13] == 3'd0) ? IDLE : NONSEQ, sz, r[10],
                  lcg_next());
        end
        issue(32'h0, IDLE, WORD, 1'b0, 32'h0);
        issue(32'h0, IDLE, WORD, 1'b0, 32'h0);

        if (DUT.asserts.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/ahb_lite_pkg.sv
rtl/ahb_lite_decoder.sv
rtl/ahb_ram_slave.sv
rtl/ahb_busy_ram_slave.sv
rtl/ahb_gpio_slave.sv
rtl/ahb_default_slave.sv
rtl/ahb_lite_response_mux.sv
rtl/ahb_lite_matrix.sv
tests/ahb_lite_matrix_asserts.sv
tests/ahb_lite_matrix_tb.sv
